/* filelist.f */
source/vmac_pkg.sv
source/vmac_latency_timer.sv
source/vmac_ctrl_fsm.sv
source/vmac_axil_regs.sv
source/vmac_lane_select.sv
source/vmac_mac_lane.sv
source/vmac_top.sv
verification/vmac_chk.sv
verification/vmac_tb.sv

/* Makefile */
TOP := vmac_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* verification/vmac_tb.sv */
`timescale 1ns/1ps

module vmac_tb
	import vmac_pkg::*;
();

	// budget per operation: four writes, status polls, two result reads
	localparam int OPS        = 12;
	localparam int OP_CYCLES  = 50;
	localparam int MAX_CYCLES = OPS * OP_CYCLES * 2;

	logic        clk;
	logic        rst_n;
	axil_req_t   req;
	axil_rsp_t   rsp;
	integer      seed;
	int          cycles;
	int          test_errs;
	int          pass_cnt;
	int          fail_cnt;
	int          ops_done;
	// 64-bit model, low bits match the 48-bit lane accumulators
	longint      model_acc [LANES];
	logic [31:0] exp_lo;
	logic [31:0] exp_hi;
	logic [31:0] d;
	logic [31:0] d0;
	logic [1:0]  resp;

	vmac_top #(.ACC_W(ACC_W), .PIPE_DEPTH(PIPE_DEPTH), .OPCNT_W(OPCNT_W)) dut0 (
		.clk(clk), .rst_n(rst_n), .axil_req(req), .axil_rsp(rsp)
	);

	bind vmac_top vmac_chk chk0 (
		.clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got == exp)
		else
		begin
			$display("FAILED %s exp %h got %h", name, exp, got);
			test_errs++;
		end
	endtask

	// ------------------------------------------------------------
	// axi4-lite driver
	// ------------------------------------------------------------
	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] bresp, input int bdelay = 0);
		@(posedge clk);
		req.awvalid <= 1'b1;
		req.awaddr  <= addr;
		req.wvalid  <= 1'b1;
		req.wdata   <= data;
		do
			@(negedge clk);
		while (!rsp.awready);
		check_val("wready", 32'd1, 32'(rsp.wready));
		@(posedge clk);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		do
			@(negedge clk);
		while (!rsp.bvalid);
		// bready held low, response has to stay put
		repeat (bdelay)
			@(negedge clk);
		bresp = rsp.bresp;
		@(posedge clk);
		req.bready <= 1'b1;
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] rresp, input int rdelay = 0);
		@(posedge clk);
		req.arvalid <= 1'b1;
		req.araddr  <= addr;
		do
			@(negedge clk);
		while (!rsp.arready);
		@(posedge clk);
		req.arvalid <= 1'b0;
		do
			@(negedge clk);
		while (!rsp.rvalid);
		repeat (rdelay)
			@(negedge clk);
		data  = rsp.rdata;
		rresp = rsp.rresp;
		@(posedge clk);
		req.rready <= 1'b1;
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic longint elem_value(input logic [31:0] word, input int idx,
		input int bits, input logic sgn);
		longint u;
		u = longint'((word >> (idx * bits)) & ((32'd1 << bits) - 32'd1));
		if (sgn && u >= (longint'(1) << (bits - 1)))
			u = u - (longint'(1) << bits);
		return u;
	endfunction

	task automatic model_op(input elem_size_e size, input mac_op_e op, input logic [2:0] sgn,
		input logic [31:0] s0, input logic [31:0] s1, input logic [31:0] s2);
		int     bits;
		int     lane;
		longint base;
		longint prod;
		bits = (size == SIZE_BYTE) ? 8 : 16;
		for (int k = 0; k < 32 / bits; k++)
		begin
			// halfwords land on lanes 0 and 3
			lane = (size == SIZE_BYTE) ? k : 3 * k;
			prod = elem_value(s0, k, bits, sgn[0]) * elem_value(s1, k, bits, sgn[1]);
			if (op == OP_MACC || op == OP_MDEC)
				base = model_acc[lane];
			else
				base = elem_value(s2, k, bits, sgn[2]);
			if (op == OP_MSUB || op == OP_MDEC)
				model_acc[lane] = base - prod;
			else
				model_acc[lane] = base + prod;
		end
		if (size == SIZE_BYTE)
		begin
			exp_lo = {model_acc[1][15:0], model_acc[0][15:0]};
			exp_hi = {model_acc[3][15:0], model_acc[2][15:0]};
		end
		else
		begin
			exp_lo = model_acc[0][31:0];
			exp_hi = model_acc[3][31:0];
		end
	endtask

	// ------------------------------------------------------------
	// operation sequencing
	// ------------------------------------------------------------
	task automatic issue_rand(input elem_size_e size, input mac_op_e op);
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] r;
		logic [1:0]  br;
		s0 = $random(seed);
		s1 = $random(seed);
		s2 = $random(seed);
		r  = $random(seed);
		axil_write(ADDR_SRC0, s0, br);
		check_val("bresp", 32'(RESP_OKAY), 32'(br));
		axil_write(ADDR_SRC1, s1, br);
		check_val("bresp", 32'(RESP_OKAY), 32'(br));
		axil_write(ADDR_SRC2, s2, br);
		check_val("bresp", 32'(RESP_OKAY), 32'(br));
		axil_write(ADDR_CTRL, {25'd0, r[2:0], 1'b0, op, size}, br);
		check_val("bresp", 32'(RESP_OKAY), 32'(br));
		model_op(size, op, r[2:0], s0, s1, s2);
		ops_done++;
	endtask

	task automatic complete_op();
		logic [31:0] st;
		logic [31:0] rd;
		logic [1:0]  rr;
		int          polls;
		polls = 0;
		st    = 32'd1;
		while (st[0] && polls < 20)
		begin
			axil_read(ADDR_STATUS, st, rr);
			polls++;
		end
		assert (!st[0])
		else
		begin
			$display("busy still set after %0d status reads", polls);
			test_errs++;
		end
		check_val("op_count", 32'(ops_done[15:0]), 32'(st[31:16]));
		axil_read(ADDR_RES_LO, rd, rr);
		check_val("res_lo", exp_lo, rd);
		axil_read(ADDR_RES_HI, rd, rr);
		check_val("res_hi", exp_hi, rd);
		check_val("rresp", 32'(RESP_OKAY), 32'(rr));
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
		begin
			pass_cnt++;
			$display("test %s passed", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	initial
	begin
		seed      = 32'hed36_645e;
		test_errs = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		ops_done  = 0;
		for (int i = 0; i < LANES; i++)
			model_acc[i] = 0;
		rst_n = 1'b0;
		req   = '0;
		repeat (4)
			@(posedge clk);
		rst_n <= 1'b1;

		issue_rand(SIZE_BYTE, OP_MADD);
		complete_op();
		end_test("byte_madd");

		// idle lanes 1 and 2 show up in the byte op that follows
		issue_rand(SIZE_HALF, OP_MSUB);
		complete_op();
		issue_rand(SIZE_HALF, OP_MSUB);
		complete_op();
		issue_rand(SIZE_BYTE, OP_MACC);
		complete_op();
		end_test("half_msub");

		issue_rand(SIZE_BYTE, OP_MADD);
		complete_op();
		repeat (3)
		begin
			issue_rand(SIZE_BYTE, OP_MACC);
			complete_op();
		end
		issue_rand(SIZE_BYTE, OP_MDEC);
		complete_op();
		end_test("feedback");

		issue_rand(SIZE_BYTE, OP_MSUB);
		axil_read(ADDR_STATUS, d, resp);
		check_val("busy", 32'd1, 32'(d[0]));
		complete_op();
		end_test("status");

		// rejected command asks for byte mode, so a wrong capture shows
		issue_rand(SIZE_HALF, OP_MADD);
		axil_write(ADDR_CTRL, 32'h0000_0006, resp);
		check_val("bresp", 32'(RESP_SLVERR), 32'(resp));
		complete_op();
		axil_read(5'h1C, d, resp);
		check_val("rresp", 32'(RESP_SLVERR), 32'(resp));
		check_val("rdata", 32'd0, d);
		axil_write(ADDR_RES_LO, 32'hffff_ffff, resp);
		check_val("bresp", 32'(RESP_SLVERR), 32'(resp));
		end_test("errors");

		d0 = $random(seed);
		axil_write(ADDR_SRC0, d0, resp, 6);
		check_val("bresp", 32'(RESP_OKAY), 32'(resp));
		axil_read(ADDR_SRC0, d, resp, 7);
		check_val("src0", d0, d);
		axil_read(ADDR_RES_HI, d, resp, 5);
		check_val("res_hi", exp_hi, d);
		end_test("backpressure");

		$display("tests passed %0d failed %0d assertion failures %0d",
			pass_cnt, fail_cnt, dut0.chk0.err_cnt);
		if (fail_cnt == 0 && dut0.chk0.err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* verification/vmac_chk.sv */
`timescale 1ns/1ps

module vmac_chk
	import vmac_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp,
	input logic      busy
);

	// failed assertions so far
	int err_cnt = 0;

	// ------------------------------------------------------------
	// response channels
	// ------------------------------------------------------------
	property b_held;
		@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp);
	endproperty

	property r_held;
		@(posedge clk) disable iff (!rst_n)
		axil_rsp.rvalid && !axil_req.rready |=>
			axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp);
	endproperty

	// no new write accepted while a response waits
	property aw_blocked;
		@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid |-> !axil_rsp.awready && !axil_rsp.wready;
	endproperty

	// controller idle while reset is held
	property busy_in_reset;
		@(posedge clk)
		!rst_n |-> !busy;
	endproperty

	a_b_held: assert property (b_held)
	else
	begin
		err_cnt++;
		$error("write response dropped or changed before bready");
	end

	a_r_held: assert property (r_held)
	else
	begin
		err_cnt++;
		$error("read response dropped or changed before rready");
	end

	a_aw_blocked: assert property (aw_blocked)
	else
	begin
		err_cnt++;
		$error("write address accepted while bvalid pending");
	end

	a_busy_in_reset: assert property (busy_in_reset)
	else
	begin
		err_cnt++;
		$error("busy set during reset");
	end

endmodule

/* source/vmac_top.sv */
`timescale 1ns/1ps

module vmac_top
	import vmac_pkg::*;
#(
	parameter int ACC_W      = vmac_pkg::ACC_W,
	parameter int PIPE_DEPTH = vmac_pkg::PIPE_DEPTH,
	parameter int OPCNT_W    = vmac_pkg::OPCNT_W
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	mac_cmd_t                    cmd;
	logic                        start;
	logic                        busy;
	logic                        issue;
	logic                        load;
	logic                        capture;
	logic                        expire;
	logic [OPCNT_W-1:0]          op_count;
	lane_opnd_t [LANES-1:0]      opnd;
	logic                        opnd_valid;
	logic [LANES-1:0][ACC_W-1:0] lane_acc;

	// ------------------------------------------------------------
	// register slave and control
	// ------------------------------------------------------------
	vmac_axil_regs #(.ACC_W(ACC_W), .OPCNT_W(OPCNT_W)) i_regs (
		.clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
		.busy(busy), .capture(capture), .lane_acc(lane_acc), .op_count(op_count),
		.cmd(cmd), .start(start)
	);

	vmac_ctrl_fsm i_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .expire(expire),
		.busy(busy), .issue(issue), .load(load), .capture(capture)
	);

	vmac_latency_timer #(.PIPE_DEPTH(PIPE_DEPTH), .OPCNT_W(OPCNT_W)) i_timer (
		.clk(clk), .rst_n(rst_n), .load(load), .expire(expire), .op_count(op_count)
	);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------
	vmac_lane_select i_select (
		.clk(clk), .rst_n(rst_n), .issue(issue), .cmd(cmd),
		.opnd(opnd), .opnd_valid(opnd_valid)
	);

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		vmac_mac_lane #(.ACC_W(ACC_W)) i_lane (
			.clk(clk), .rst_n(rst_n), .opnd_valid(opnd_valid),
			.opnd(opnd[i]), .acc(lane_acc[i])
		);
	end

endmodule

/* source/vmac_mac_lane.sv */
`timescale 1ns/1ps

module vmac_mac_lane
	import vmac_pkg::*;
#(
	parameter int ACC_W = vmac_pkg::ACC_W
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             opnd_valid,
	input  lane_opnd_t       opnd,
	output logic [ACC_W-1:0] acc
);

	lane_opnd_t                in_q;
	logic                      v_in;
	logic                      v_mul;
	logic signed [2*MUL_W-1:0] prod_q;
	logic signed [ACC_W-1:0]   base_q;
	logic                      fb_q;
	logic                      sub_q;
	logic signed [ACC_W-1:0]   acc_q;
	logic signed [ACC_W-1:0]   acc_base;

	assign acc      = acc_q;
	assign acc_base = fb_q ? acc_q : base_q;

	// valid travels with the data
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			v_in  <= 1'b0;
			v_mul <= 1'b0;
		end
		else
		begin
			v_in  <= opnd_valid;
			v_mul <= v_in;
		end
	end

	// ------------------------------------------------------------
	// input and product stages
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (opnd_valid)
			in_q <= opnd;
		prod_q <= in_q.mul_a * in_q.mul_b;
		base_q <= ACC_W'(in_q.base);
		fb_q   <= in_q.feedback;
		sub_q  <= in_q.subtract;
	end

	// accumulate stage
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			acc_q <= '0;
		else if (v_mul)
			acc_q <= sub_q ? acc_base - ACC_W'(prod_q) : acc_base + ACC_W'(prod_q);
	end

endmodule

/* source/vmac_lane_select.sv */
`timescale 1ns/1ps

module vmac_lane_select
	import vmac_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue,
	input  mac_cmd_t               cmd,
	output lane_opnd_t [LANES-1:0] opnd,
	output logic                   opnd_valid
);

	lane_opnd_t [LANES-1:0] opnd_d;
	logic                   fb;
	logic                   sub;

	// sign or zero extension of one element to multiplier width
	function automatic logic signed [MUL_W-1:0] ext_elem(
		input logic [15:0] v,
		input logic        sgn,
		input elem_size_e  size
	);
		if (size == SIZE_BYTE)
			ext_elem = {{(MUL_W-8){sgn & v[7]}}, v[7:0]};
		else
			ext_elem = {{(MUL_W-16){sgn & v[15]}}, v};
	endfunction

	assign fb  = (cmd.op == OP_MACC) || (cmd.op == OP_MDEC);
	assign sub = (cmd.op == OP_MSUB) || (cmd.op == OP_MDEC);

	// ------------------------------------------------------------
	// lane routing by element size
	// ------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			opnd_d[i].feedback = fb;
			opnd_d[i].subtract = sub;
			if (cmd.size == SIZE_BYTE)
			begin
				opnd_d[i].mul_a = ext_elem(16'(cmd.src0[8*i +: 8]), cmd.src0_sign, SIZE_BYTE);
				opnd_d[i].mul_b = ext_elem(16'(cmd.src1[8*i +: 8]), cmd.src1_sign, SIZE_BYTE);
				opnd_d[i].base  = ACC_W'(ext_elem(16'(cmd.src2[8*i +: 8]), cmd.src2_sign,
					SIZE_BYTE));
			end
			else if (i == 0 || i == LANES-1)
			begin
				// halfword 0 to lane 0, halfword 1 to the top lane
				opnd_d[i].mul_a = ext_elem((i == 0) ? cmd.src0[15:0] : cmd.src0[31:16],
					cmd.src0_sign, SIZE_HALF);
				opnd_d[i].mul_b = ext_elem((i == 0) ? cmd.src1[15:0] : cmd.src1[31:16],
					cmd.src1_sign, SIZE_HALF);
				opnd_d[i].base  = ACC_W'(ext_elem((i == 0) ? cmd.src2[15:0] : cmd.src2[31:16],
					cmd.src2_sign, SIZE_HALF));
			end
			else
			begin
				// idle lane, acc + 0 keeps its value
				opnd_d[i].mul_a    = '0;
				opnd_d[i].mul_b    = '0;
				opnd_d[i].base     = '0;
				opnd_d[i].feedback = 1'b1;
				opnd_d[i].subtract = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			opnd_valid <= 1'b0;
		else
			opnd_valid <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			opnd <= opnd_d;
	end

endmodule

/* source/vmac_axil_regs.sv */
`timescale 1ns/1ps

module vmac_axil_regs
	import vmac_pkg::*;
#(
	parameter int ACC_W   = vmac_pkg::ACC_W,
	parameter int OPCNT_W = vmac_pkg::OPCNT_W
)
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  axil_req_t                   axil_req,
	output axil_rsp_t                   axil_rsp,
	input  logic                        busy,
	input  logic                        capture,
	input  logic [LANES-1:0][ACC_W-1:0] lane_acc,
	input  logic [OPCNT_W-1:0]          op_count,
	output mac_cmd_t                    cmd,
	output logic                        start
);

	axil_rsp_t         rsp_q;
	mac_cmd_t          cmd_q;
	logic [DATA_W-1:0] res_lo;
	logic [DATA_W-1:0] res_hi;
	logic [DATA_W-1:0] res_lo_nxt;
	logic [DATA_W-1:0] res_hi_nxt;
	logic [DATA_W-1:0] ctrl_word;
	logic [DATA_W-1:0] status;
	logic [DATA_W-1:0] rd_data;
	logic              rd_ok;
	logic              wr_ok;
	logic              aw_go;
	logic              ar_go;
	logic              wr_en;
	logic              rd_en;

	assign axil_rsp = rsp_q;
	assign cmd      = cmd_q;

	// ready pulses for one cycle, only while no response is pending
	assign aw_go = !rsp_q.awready && !rsp_q.bvalid && axil_req.awvalid && axil_req.wvalid;
	assign ar_go = !rsp_q.arready && !rsp_q.rvalid && axil_req.arvalid;
	assign wr_en = rsp_q.awready && axil_req.awvalid && axil_req.wvalid;
	assign rd_en = rsp_q.arready && axil_req.arvalid;
	assign start = wr_en && (axil_req.awaddr == ADDR_CTRL) && !busy;

	assign ctrl_word = {25'd0, cmd_q.src2_sign, cmd_q.src1_sign, cmd_q.src0_sign,
		1'b0, cmd_q.op, cmd_q.size};
	assign status    = {16'(op_count), 15'd0, busy};

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	always_comb
	begin
		unique case (axil_req.awaddr)
			ADDR_SRC0, ADDR_SRC1, ADDR_SRC2: wr_ok = 1'b1;
			ADDR_CTRL:                       wr_ok = !busy;
			default:                         wr_ok = 1'b0;
		endcase
	end

	always_comb
	begin
		rd_ok   = 1'b1;
		rd_data = '0;
		unique case (axil_req.araddr)
			ADDR_SRC0:   rd_data = cmd_q.src0;
			ADDR_SRC1:   rd_data = cmd_q.src1;
			ADDR_SRC2:   rd_data = cmd_q.src2;
			ADDR_CTRL:   rd_data = ctrl_word;
			ADDR_RES_LO: rd_data = res_lo;
			ADDR_RES_HI: rd_data = res_hi;
			ADDR_STATUS: rd_data = status;
			default:     rd_ok   = 1'b0;
		endcase
	end

	// byte lanes give 16 bits each, halfword lanes 0 and 3 give 32
	always_comb
	begin
		if (cmd_q.size == SIZE_BYTE)
		begin
			res_lo_nxt = {lane_acc[1][15:0], lane_acc[0][15:0]};
			res_hi_nxt = {lane_acc[3][15:0], lane_acc[2][15:0]};
		end
		else
		begin
			res_lo_nxt = lane_acc[0][31:0];
			res_hi_nxt = lane_acc[3][31:0];
		end
	end

	// ------------------------------------------------------------
	// channel handshakes
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rsp_q <= '0;
		end
		else
		begin
			rsp_q.awready <= aw_go;
			rsp_q.wready  <= aw_go;
			rsp_q.arready <= ar_go;
			if (wr_en)
			begin
				rsp_q.bvalid <= 1'b1;
				rsp_q.bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end
			else if (rsp_q.bvalid && axil_req.bready)
				rsp_q.bvalid <= 1'b0;
			if (rd_en)
			begin
				rsp_q.rvalid <= 1'b1;
				rsp_q.rdata  <= rd_data;
				rsp_q.rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			end
			else if (rsp_q.rvalid && axil_req.rready)
				rsp_q.rvalid <= 1'b0;
		end
	end

	// operand, command and result registers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_q  <= '0;
			res_lo <= '0;
			res_hi <= '0;
		end
		else
		begin
			if (wr_en && wr_ok)
			begin
				unique case (axil_req.awaddr)
					ADDR_SRC0: cmd_q.src0 <= axil_req.wdata;
					ADDR_SRC1: cmd_q.src1 <= axil_req.wdata;
					ADDR_SRC2: cmd_q.src2 <= axil_req.wdata;
					default:
					begin
						cmd_q.size      <= elem_size_e'(axil_req.wdata[0]);
						cmd_q.op        <= mac_op_e'(axil_req.wdata[2:1]);
						cmd_q.src0_sign <= axil_req.wdata[4];
						cmd_q.src1_sign <= axil_req.wdata[5];
						cmd_q.src2_sign <= axil_req.wdata[6];
					end
				endcase
			end
			if (capture)
			begin
				res_lo <= res_lo_nxt;
				res_hi <= res_hi_nxt;
			end
		end
	end

endmodule

/* source/vmac_ctrl_fsm.sv */
`timescale 1ns/1ps

module vmac_ctrl_fsm
	import vmac_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic expire,
	output logic busy,
	output logic issue,
	output logic load,
	output logic capture
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		unique case (state)
			ST_IDLE:
			begin
				if (start)
					state_nxt = ST_ISSUE;
			end
			// single cycle, operands go to the lanes
			ST_ISSUE:
				state_nxt = ST_WAIT;
			// pipeline still filling
			ST_WAIT:
			begin
				if (expire)
					state_nxt = ST_CAPTURE;
			end
			ST_CAPTURE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	// ------------------------------------------------------------
	// outputs decoded from state
	// ------------------------------------------------------------
	assign busy    = (state != ST_IDLE);
	assign issue   = (state == ST_ISSUE);
	assign load    = (state == ST_ISSUE);
	assign capture = (state == ST_CAPTURE);

endmodule

/* source/vmac_latency_timer.sv */
`timescale 1ns/1ps

module vmac_latency_timer
#(
	parameter int PIPE_DEPTH = 4,
	parameter int OPCNT_W    = 16
)
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               load,
	output logic               expire,
	output logic [OPCNT_W-1:0] op_count
);

	localparam int CNT_W = $clog2(PIPE_DEPTH + 1);

	logic [CNT_W-1:0] cnt;

	// last cycle of the countdown
	assign expire = (cnt == CNT_W'(1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt      <= '0;
			op_count <= '0;
		end
		else
		begin
			if (load)
				cnt <= CNT_W'(PIPE_DEPTH);
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
			// wraps freely
			if (expire)
				op_count <= op_count + 1'b1;
		end
	end

endmodule

/* source/vmac_pkg.sv */
package vmac_pkg;

	// ------------------------------------------------------------
	// widths and defaults
	// ------------------------------------------------------------
	parameter int DATA_W     = 32;
	parameter int ADDR_W     = 5;
	parameter int MUL_W      = 18;
	parameter int ACC_W      = 48;
	parameter int LANES      = 4;
	parameter int PIPE_DEPTH = 4;
	parameter int OPCNT_W    = 16;

	// register map, byte addresses
	parameter logic [ADDR_W-1:0] ADDR_SRC0   = 5'h00;
	parameter logic [ADDR_W-1:0] ADDR_SRC1   = 5'h04;
	parameter logic [ADDR_W-1:0] ADDR_SRC2   = 5'h08;
	parameter logic [ADDR_W-1:0] ADDR_CTRL   = 5'h0C;
	parameter logic [ADDR_W-1:0] ADDR_RES_LO = 5'h10;
	parameter logic [ADDR_W-1:0] ADDR_RES_HI = 5'h14;
	parameter logic [ADDR_W-1:0] ADDR_STATUS = 5'h18;

	// axi response codes
	parameter logic [1:0] RESP_OKAY   = 2'b00;
	parameter logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic {
		SIZE_BYTE = 1'b0,
		SIZE_HALF = 1'b1
	} elem_size_e;

	// madd/msub start from src2, macc/mdec from the lane accumulator
	typedef enum logic [1:0] {
		OP_MADD = 2'd0,
		OP_MSUB = 2'd1,
		OP_MACC = 2'd2,
		OP_MDEC = 2'd3
	} mac_op_e;

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_ISSUE   = 2'd1,
		ST_WAIT    = 2'd2,
		ST_CAPTURE = 2'd3
	} ctrl_state_e;

	// ------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------
	typedef struct packed {
		elem_size_e        size;
		mac_op_e           op;
		logic              src0_sign;
		logic              src1_sign;
		logic              src2_sign;
		logic [DATA_W-1:0] src0;
		logic [DATA_W-1:0] src1;
		logic [DATA_W-1:0] src2;
	} mac_cmd_t;

	typedef struct packed {
		logic signed [MUL_W-1:0] mul_a;
		logic signed [MUL_W-1:0] mul_b;
		logic signed [ACC_W-1:0] base;
		logic                    feedback;
		logic                    subtract;
	} lane_opnd_t;

	typedef struct packed {
		logic              awvalid;
		logic [ADDR_W-1:0] awaddr;
		logic              wvalid;
		logic [DATA_W-1:0] wdata;
		logic              bready;
		logic              arvalid;
		logic [ADDR_W-1:0] araddr;
		logic              rready;
	} axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		logic [1:0]        bresp;
		logic              arready;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		logic [1:0]        rresp;
	} axil_rsp_t;

endpackage
